/* cache_pkg.sv */
/* geometry is fixed: 4 KB, 4 ways, 16 sets of 64-byte lines, 64-bit words, 32-bit addresses
   the memory side is assumed to use 8-byte beats in 8-beat wrapping bursts */
package cache_pkg;

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 64;
    localparam int STRB_W         = 8;
    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 16;
    localparam int INDEX_W        = 4;
    localparam int OFFSET_W       = 6;
    localparam int TAG_W          = 22;
    localparam int WORD_OFFSET_W  = 3;
    localparam int BEATS_PER_LINE = 8;

    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;       // addr[31:10]
        logic [INDEX_W-1:0]  index;     // addr[9:6]
        logic [OFFSET_W-1:0] offset;    // byte within line
    } addr_fields_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic             hit;
        way_t             hit_way;
        way_t             empty_way;    // lowest invalid way
        logic             full;         // no invalid way in set
        logic             victim_dirty;
        logic [TAG_W-1:0] victim_tag;
    } lookup_t;

    typedef enum logic [2:0] {
        st_idle,
        st_read_hit,
        st_write_hit,
        st_write_back,
        st_refill,
        st_read_miss,
        st_write_miss
    } cache_state_e;

    typedef struct packed {
        logic                     rd_en;
        logic                     wr_en;
        way_t                     way;
        logic [INDEX_W-1:0]       set;
        logic [WORD_OFFSET_W-1:0] word;
        logic [DATA_W-1:0]        wdata;
        logic [STRB_W-1:0]        strb;
    } data_access_t;

endpackage

/* cache_tag_array.sv */
/* tag store with combinational lookup and write at the clock edge
   only the valid bits are cleared by reset */
`timescale 1ns/1ps

module cache_tag_array (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [cache_pkg::INDEX_W-1:0]   set,
    input  logic [cache_pkg::TAG_W-1:0]     tag,
    input  cache_pkg::way_t                 victim_way,
    input  logic                            w_en,
    input  cache_pkg::way_t                 w_way,
    input  cache_pkg::tag_entry_t           w_entry,
    output cache_pkg::lookup_t              lookup
);
    logic [cache_pkg::NUM_WAYS-1:0] valid_q [cache_pkg::NUM_SETS];
    logic [cache_pkg::NUM_WAYS-1:0] dirty_q [cache_pkg::NUM_SETS];
    logic [cache_pkg::TAG_W-1:0]    tag_q   [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic [cache_pkg::NUM_WAYS-1:0] hit_vec;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (w_en) begin
            valid_q[set][w_way] <= w_entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (w_en) begin
            dirty_q[set][w_way] <= w_entry.dirty;
            tag_q[set][w_way]   <= w_entry.tag;
        end
    end

    always_comb begin
        lookup = '0;
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin   // downward so lowest way wins
            hit_vec[w] = valid_q[set][w] && (tag_q[set][w] == tag);
            if (hit_vec[w]) begin
                lookup.hit     = 1'b1;
                lookup.hit_way = cache_pkg::way_t'(w);
            end
            if (!valid_q[set][w]) begin
                lookup.empty_way = cache_pkg::way_t'(w);
            end
        end
        lookup.full         = &valid_q[set];
        lookup.victim_dirty = valid_q[set][victim_way] && dirty_q[set][victim_way];
        lookup.victim_tag   = tag_q[set][victim_way];
    end

    // a line is only ever allocated after a miss, so duplicates mean a broken controller
    a_single_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec));

endmodule

/* cache_data_array.sv */
/* line data store, 16 sets x 4 ways x 8 words, byte-strobed writes
   read data is registered and holds until the next read */
`timescale 1ns/1ps

module cache_data_array (
    input  logic                           clk,
    input  cache_pkg::data_access_t        access,
    output logic [cache_pkg::DATA_W-1:0]   rd_data
);
    localparam int DEPTH  = cache_pkg::NUM_SETS * cache_pkg::NUM_WAYS * cache_pkg::BEATS_PER_LINE;
    localparam int ADDR_W = $clog2(DEPTH);

    logic [cache_pkg::DATA_W-1:0] mem [DEPTH];
    logic [ADDR_W-1:0]            addr;

    assign addr = {access.set, access.way, access.word};   // set-major layout

    always_ff @(posedge clk) begin
        if (access.wr_en) begin
            for (int b = 0; b < cache_pkg::STRB_W; b++) begin
                if (access.strb[b]) begin
                    mem[addr][b*8 +: 8] <= access.wdata[b*8 +: 8];
                end
            end
        end
        if (access.rd_en) begin
            rd_data <= mem[addr];
        end
    end

    // one port, the controller never mixes a read and a write in one cycle
    a_no_rd_wr: assert property (@(posedge clk) !(access.rd_en && access.wr_en));

endmodule

/* cache_ctrl.sv */
/* requests are sampled only in idle and must stay stable until cpu_r_valid or cpu_w_ready
   memory bursts are 8 beats of 8 bytes, wrapping from the requested word */
`timescale 1ns/1ps

module cache_ctrl #(
    parameter logic [7:0] LFSR_SEED = 8'd1
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [cache_pkg::ADDR_W-1:0]      cpu_addr,
    input  logic                              cpu_r_req,
    input  logic                              cpu_w_req,
    input  logic [cache_pkg::DATA_W-1:0]      cpu_w_data,
    input  logic [cache_pkg::STRB_W-1:0]      cpu_w_strb,
    output logic                              cpu_r_valid,
    output logic                              cpu_w_ready,
    input  cache_pkg::lookup_t                lookup,
    output logic [cache_pkg::INDEX_W-1:0]     lookup_set,
    output logic [cache_pkg::TAG_W-1:0]       lookup_tag,
    output cache_pkg::way_t                   victim_way,
    output logic                              tag_w_en,
    output cache_pkg::way_t                   tag_w_way,
    output cache_pkg::tag_entry_t             tag_w_entry,
    output cache_pkg::data_access_t           access,
    input  logic [cache_pkg::DATA_W-1:0]      rd_data,
    output logic [cache_pkg::ADDR_W-1:0]      mem_r_addr,
    output logic                              mem_r_ready,
    input  logic                              mem_r_valid,
    input  logic [cache_pkg::DATA_W-1:0]      mem_r_data,
    output logic [cache_pkg::ADDR_W-1:0]      mem_w_addr,
    output logic                              mem_w_valid,
    input  logic                              mem_w_ready,
    output logic [cache_pkg::DATA_W-1:0]      mem_w_data
);
    localparam int BYTE_W = cache_pkg::OFFSET_W - cache_pkg::WORD_OFFSET_W;
    localparam logic [cache_pkg::WORD_OFFSET_W-1:0] LAST_BEAT =
        cache_pkg::WORD_OFFSET_W'(cache_pkg::BEATS_PER_LINE - 1);

    cache_pkg::cache_state_e                state;
    cache_pkg::addr_fields_t                cur_addr;
    cache_pkg::addr_fields_t                req_addr;
    logic                                   req_write;
    cache_pkg::way_t                        way_r;      // hit, empty or victim way
    logic [cache_pkg::WORD_OFFSET_W-1:0]    req_word;
    logic [cache_pkg::WORD_OFFSET_W-1:0]    word_ptr;   // wrapping burst position
    logic [cache_pkg::WORD_OFFSET_W-1:0]    beat_cnt;
    logic [7:0]                             lfsr;
    logic                                   last_beat;

    assign cur_addr   = (state == cache_pkg::st_idle) ? cache_pkg::addr_fields_t'(cpu_addr)
                                                      : req_addr;
    assign lookup_set = cur_addr.index;
    assign lookup_tag = cur_addr.tag;
    assign victim_way = (state == cache_pkg::st_idle) ? lfsr[1:0] : way_r;
    assign req_word   = req_addr.offset[cache_pkg::OFFSET_W-1 -: cache_pkg::WORD_OFFSET_W];
    assign last_beat  = (beat_cnt == LAST_BEAT);

    assign mem_r_addr = {req_addr.tag, req_addr.index, req_word, {BYTE_W{1'b0}}};
    assign mem_w_addr = {lookup.victim_tag, req_addr.index, req_word, {BYTE_W{1'b0}}};
    assign mem_w_data = rd_data;                       // read one beat ahead

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= cache_pkg::st_idle;
            cpu_r_valid <= 1'b0;
            mem_w_valid <= 1'b0;
            beat_cnt    <= '0;
            lfsr        <= LFSR_SEED;
        end else begin
            cpu_r_valid <= 1'b0;
            case (state)
                cache_pkg::st_idle: begin
                    if (cpu_r_req || cpu_w_req) begin
                        req_addr  <= cur_addr;
                        req_write <= cpu_w_req;
                        word_ptr  <= cur_addr.offset[cache_pkg::OFFSET_W-1 -: cache_pkg::WORD_OFFSET_W];
                        beat_cnt  <= '0;
                        if (lookup.hit) begin
                            way_r <= lookup.hit_way;
                            state <= cpu_w_req ? cache_pkg::st_write_hit : cache_pkg::st_read_hit;
                        end else if (lookup.full) begin
                            way_r <= lfsr[1:0];              // random victim
                            state <= lookup.victim_dirty ? cache_pkg::st_write_back
                                                         : cache_pkg::st_refill;
                        end else begin
                            way_r <= lookup.empty_way;
                            state <= cache_pkg::st_refill;
                        end
                    end
                end
                cache_pkg::st_read_hit: begin
                    if (cpu_r_valid) begin
                        state <= cache_pkg::st_idle;         // cpu drops request on this edge
                    end else begin
                        cpu_r_valid <= 1'b1;
                    end
                end
                cache_pkg::st_write_hit: begin
                    state <= cache_pkg::st_idle;
                end
                cache_pkg::st_write_back: begin
                    if (access.rd_en) begin
                        word_ptr <= word_ptr + 1'b1;
                    end
                    if (!mem_w_valid) begin
                        mem_w_valid <= 1'b1;                 // first word now in rd_data
                    end else if (mem_w_ready) begin
                        beat_cnt <= beat_cnt + 1'b1;         // wraps to 0 for the refill
                        if (last_beat) begin
                            mem_w_valid <= 1'b0;
                            lfsr        <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
                            word_ptr    <= req_word;
                            state       <= cache_pkg::st_refill;
                        end
                    end
                end
                cache_pkg::st_refill: begin
                    if (mem_r_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        word_ptr <= word_ptr + 1'b1;
                        if (beat_cnt == '0) begin
                            state <= req_write ? cache_pkg::st_write_miss
                                               : cache_pkg::st_read_miss;
                        end else if (last_beat) begin
                            state <= cache_pkg::st_idle;
                        end
                    end
                end
                cache_pkg::st_read_miss: begin
                    cpu_r_valid <= 1'b1;
                    state       <= cache_pkg::st_refill;
                end
                cache_pkg::st_write_miss: begin
                    state <= cache_pkg::st_refill;
                end
                default: begin
                    state <= cache_pkg::st_idle;
                end
            endcase
        end
    end

    always_comb begin
        access            = '0;
        access.way        = way_r;
        access.set        = req_addr.index;
        access.word       = req_word;
        access.wdata      = cpu_w_data;
        access.strb       = cpu_w_strb;
        tag_w_en          = 1'b0;
        tag_w_way         = way_r;
        tag_w_entry.valid = 1'b1;
        tag_w_entry.dirty = req_write;
        tag_w_entry.tag   = req_addr.tag;
        cpu_w_ready       = 1'b0;
        mem_r_ready       = 1'b0;
        case (state)
            cache_pkg::st_read_hit: begin
                access.rd_en = !cpu_r_valid;
            end
            cache_pkg::st_write_hit: begin
                access.wr_en = 1'b1;
                tag_w_en     = 1'b1;                         // mark line dirty
                cpu_w_ready  = 1'b1;
            end
            cache_pkg::st_write_back: begin
                access.word  = word_ptr;
                access.rd_en = !mem_w_valid || (mem_w_ready && !last_beat);
            end
            cache_pkg::st_refill: begin
                mem_r_ready  = 1'b1;
                access.word  = word_ptr;
                access.wr_en = mem_r_valid;
                access.wdata = mem_r_data;
                access.strb  = '1;
                tag_w_en     = mem_r_valid && last_beat;
            end
            cache_pkg::st_read_miss: begin
                access.rd_en = 1'b1;
            end
            cache_pkg::st_write_miss: begin
                access.wr_en = 1'b1;                         // cpu bytes over refilled word
                cpu_w_ready  = 1'b1;
            end
            default: begin
                tag_w_en = 1'b0;
            end
        endcase
    end

    a_one_response: assert property (@(posedge clk) disable iff (rst)
        !(cpu_r_valid && cpu_w_ready));

    a_wb_window: assert property (@(posedge clk) disable iff (rst)
        mem_w_valid |-> state == cache_pkg::st_write_back);

endmodule

/* cache_top.sv */
/* 4 KB write-back data cache, CPU and memory ports only
   LFSR_SEED must be nonzero */
`timescale 1ns/1ps

module cache_top #(
    parameter logic [7:0] LFSR_SEED = 8'd1
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [cache_pkg::ADDR_W-1:0]      cpu_addr,
    input  logic                              cpu_r_req,
    input  logic                              cpu_w_req,
    input  logic [cache_pkg::DATA_W-1:0]      cpu_w_data,
    input  logic [cache_pkg::STRB_W-1:0]      cpu_w_strb,
    output logic [cache_pkg::DATA_W-1:0]      cpu_r_data,
    output logic                              cpu_r_valid,
    output logic                              cpu_w_ready,
    output logic [cache_pkg::ADDR_W-1:0]      mem_r_addr,
    output logic                              mem_r_ready,
    input  logic                              mem_r_valid,
    input  logic [cache_pkg::DATA_W-1:0]      mem_r_data,
    output logic [cache_pkg::ADDR_W-1:0]      mem_w_addr,
    output logic                              mem_w_valid,
    input  logic                              mem_w_ready,
    output logic [cache_pkg::DATA_W-1:0]      mem_w_data
);
    cache_pkg::lookup_t                lookup;
    logic [cache_pkg::INDEX_W-1:0]     lookup_set;
    logic [cache_pkg::TAG_W-1:0]       lookup_tag;
    cache_pkg::way_t                   victim_way;
    logic                              tag_w_en;
    cache_pkg::way_t                   tag_w_way;
    cache_pkg::tag_entry_t             tag_w_entry;
    cache_pkg::data_access_t           access;

    cache_ctrl #(
        .LFSR_SEED (LFSR_SEED)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cpu_addr    (cpu_addr),
        .cpu_r_req   (cpu_r_req),
        .cpu_w_req   (cpu_w_req),
        .cpu_w_data  (cpu_w_data),
        .cpu_w_strb  (cpu_w_strb),
        .cpu_r_valid (cpu_r_valid),
        .cpu_w_ready (cpu_w_ready),
        .lookup      (lookup),
        .lookup_set  (lookup_set),
        .lookup_tag  (lookup_tag),
        .victim_way  (victim_way),
        .tag_w_en    (tag_w_en),
        .tag_w_way   (tag_w_way),
        .tag_w_entry (tag_w_entry),
        .access      (access),
        .rd_data     (cpu_r_data),      // same word feeds cpu and write-back
        .mem_r_addr  (mem_r_addr),
        .mem_r_ready (mem_r_ready),
        .mem_r_valid (mem_r_valid),
        .mem_r_data  (mem_r_data),
        .mem_w_addr  (mem_w_addr),
        .mem_w_valid (mem_w_valid),
        .mem_w_ready (mem_w_ready),
        .mem_w_data  (mem_w_data)
    );

    cache_tag_array u_tags (
        .clk        (clk),
        .rst        (rst),
        .set        (lookup_set),
        .tag        (lookup_tag),
        .victim_way (victim_way),
        .w_en       (tag_w_en),
        .w_way      (tag_w_way),
        .w_entry    (tag_w_entry),
        .lookup     (lookup)
    );

    cache_data_array u_data (
        .clk     (clk),
        .access  (access),
        .rd_data (cpu_r_data)
    );

endmodule

/* tb_cache.sv */
/* needs the cache at its default geometry; test addresses keep addr[31:13] and addr[9:8]
   at zero so that the 2 KB memory model holds every line that the test touches */
`timescale 1ns/1ps

module tb_cache;
    localparam int IDLE_TIMEOUT = 200;
    localparam int RESP_TIMEOUT = 400;
    localparam int ANY  = 0;
    localparam int HIT  = 1;
    localparam int MISS = 2;

    logic                             clk;
    logic                             rst         = 1'b1;
    logic [cache_pkg::ADDR_W-1:0]     cpu_addr    = '0;
    logic                             cpu_r_req   = 1'b0;
    logic                             cpu_w_req   = 1'b0;
    logic [cache_pkg::DATA_W-1:0]     cpu_w_data  = '0;
    logic [cache_pkg::STRB_W-1:0]     cpu_w_strb  = '0;
    logic [cache_pkg::DATA_W-1:0]     cpu_r_data;
    logic                             cpu_r_valid;
    logic                             cpu_w_ready;
    logic [cache_pkg::ADDR_W-1:0]     mem_r_addr;
    logic                             mem_r_ready;
    logic                             mem_r_valid = 1'b0;
    logic [cache_pkg::DATA_W-1:0]     mem_r_data  = '0;
    logic [cache_pkg::ADDR_W-1:0]     mem_w_addr;
    logic                             mem_w_valid;
    logic                             mem_w_ready = 1'b0;
    logic [cache_pkg::DATA_W-1:0]     mem_w_data;

    logic [31:0]                      lfsr_q = 32'he0b8_dd25;
    logic [cache_pkg::DATA_W-1:0]     mem_model [256];     // backing store of 2 KB
    logic [7:0]                       image [2048];        // golden byte image
    logic                             line_dirty [32];     // written since last write-back
    logic [cache_pkg::DATA_W-1:0]     exp_q [$];           // pending read results
    logic                             rd_active = 1'b0;
    logic [3:0]                       rd_beat = '0;
    logic [cache_pkg::ADDR_W-1:0]     rd_base = '0;
    logic [2:0]                       wb_beat = '0;
    int                               wb_bursts = 0;
    int                               data_errs = 0;
    int                               addr_errs = 0;
    int                               ctrl_errs = 0;
    int                               other_errs = 0;
    logic                             timed_out = 1'b0;

    cache_top #(
        .LFSR_SEED (8'h5d)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .cpu_addr    (cpu_addr),
        .cpu_r_req   (cpu_r_req),
        .cpu_w_req   (cpu_w_req),
        .cpu_w_data  (cpu_w_data),
        .cpu_w_strb  (cpu_w_strb),
        .cpu_r_data  (cpu_r_data),
        .cpu_r_valid (cpu_r_valid),
        .cpu_w_ready (cpu_w_ready),
        .mem_r_addr  (mem_r_addr),
        .mem_r_ready (mem_r_ready),
        .mem_r_valid (mem_r_valid),
        .mem_r_data  (mem_r_data),
        .mem_w_addr  (mem_w_addr),
        .mem_w_valid (mem_w_valid),
        .mem_w_ready (mem_w_ready),
        .mem_w_data  (mem_w_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    function automatic logic [cache_pkg::DATA_W-1:0] rand_word();
        return {rand_bits(32), rand_bits(32)};
    endfunction

    function automatic logic [31:0] make_addr(input logic [2:0] tag, input logic [1:0] set,
                                              input logic [2:0] word);
        return {19'd0, tag, 2'b00, set, word, 3'b000};
    endfunction

    function automatic logic [7:0] mem_index(input logic [31:0] a);
        return {a[12:10], a[7:6], a[5:3]};   // tag low bits, set low bits, word
    endfunction

    function automatic logic [4:0] line_index(input logic [31:0] a);
        return {a[12:10], a[7:6]};
    endfunction

    // reference model returns the image word
    function automatic logic [cache_pkg::DATA_W-1:0] ref_word(input logic [31:0] a);
        logic [cache_pkg::DATA_W-1:0] w;
        for (int b = 0; b < cache_pkg::STRB_W; b++) begin
            w[b*8 +: 8] = image[{mem_index(a), 3'(b)}];
        end
        return w;
    endfunction

    task automatic image_merge(input logic [31:0] a, input logic [cache_pkg::DATA_W-1:0] d,
                               input logic [cache_pkg::STRB_W-1:0] s);
        for (int b = 0; b < cache_pkg::STRB_W; b++) begin
            if (s[b]) begin
                image[{mem_index(a), 3'(b)}] = d[b*8 +: 8];
            end
        end
    endtask

    task automatic fill_memory();
        logic [31:0]                  a;
        logic [cache_pkg::DATA_W-1:0] w;
        for (int i = 0; i < 256; i++) begin
            a = make_addr(3'(i >> 5), 2'(i >> 3), 3'(i));
            w = {a ^ 32'h3c5a_96e1, a};
            mem_model[mem_index(a)] = w;
            line_dirty[line_index(a)] = 1'b0;
            for (int b = 0; b < cache_pkg::STRB_W; b++) begin
                image[{mem_index(a), 3'(b)}] = w[b*8 +: 8];
            end
        end
    endtask

    task automatic check_data(input string name, input logic [cache_pkg::DATA_W-1:0] exp,
                              input logic [cache_pkg::DATA_W-1:0] got);
        if (got !== exp) begin
            data_errs++;
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_addr(input string name, input logic [cache_pkg::ADDR_W-1:0] exp,
                              input logic [cache_pkg::ADDR_W-1:0] got);
        if (got !== exp) begin
            addr_errs++;
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_wb_beat(input logic [cache_pkg::ADDR_W-1:0] exp_a,
                                 input logic [cache_pkg::ADDR_W-1:0] got_a,
                                 input logic [cache_pkg::DATA_W-1:0] exp_d,
                                 input logic [cache_pkg::DATA_W-1:0] got_d);
        check_addr("mem_w_addr", exp_a, got_a);
        check_data("mem_w_data", exp_d, got_d);
    endtask

    task automatic check_level(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            ctrl_errs++;
            $display("ERROR %0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        if (got != exp) begin
            ctrl_errs++;
            $display("ERROR %0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    // idle needs two quiet samples since read_miss drops mem_r_ready for one
    task automatic wait_idle();
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 2 && cycles < IDLE_TIMEOUT && !timed_out) begin
            @(posedge clk);
            cycles++;
            quiet = (mem_r_ready || mem_w_valid) ? 0 : quiet + 1;
        end
        if (quiet < 2 && !timed_out) begin
            timed_out = 1'b1;
            other_errs++;
            $display("timeout at %0t: the cache never went back to idle", $time);
        end
    endtask

    task automatic wait_response(output int cycles, output logic traffic);
        logic done;
        cycles  = 0;
        traffic = 1'b0;
        done    = 1'b0;
        while (!done && cycles < RESP_TIMEOUT && !timed_out) begin
            @(posedge clk);
            cycles++;
            traffic = traffic | mem_r_ready | mem_w_valid;
            done    = cpu_r_valid || cpu_w_ready;
        end
        if (!done && !timed_out) begin
            timed_out = 1'b1;
            other_errs++;
            $display("timeout at %0t: no response to the request at %h", $time, cpu_addr);
        end
    endtask

    task automatic check_timing(input int mode, input int hit_lat, input int cycles,
                                input logic traffic);
        if (timed_out) begin
            return;
        end
        if (mode == HIT) begin
            check_count("hit latency", hit_lat, cycles - 1);   // first edge samples the request
            if (traffic) begin
                other_errs++;
                $display("memory traffic at %0t during a hit to %h", $time, cpu_addr);
            end
        end else if (mode == MISS && !traffic) begin
            other_errs++;
            $display("a miss to %h at %0t caused no memory burst", cpu_addr, $time);
        end
    endtask

    task automatic cpu_read(input logic [31:0] a, input int mode);
        int   cycles;
        logic traffic;
        wait_idle();
        cpu_addr  <= a;
        cpu_r_req <= 1'b1;
        exp_q.push_back(ref_word(a));
        wait_response(cycles, traffic);
        cpu_r_req <= 1'b0;
        check_timing(mode, 2, cycles, traffic);
    endtask

    task automatic cpu_write(input logic [31:0] a, input logic [cache_pkg::DATA_W-1:0] d,
                             input logic [cache_pkg::STRB_W-1:0] s, input int mode);
        int   cycles;
        logic traffic;
        wait_idle();
        cpu_addr   <= a;
        cpu_w_data <= d;
        cpu_w_strb <= s;
        cpu_w_req  <= 1'b1;
        image_merge(a, d, s);
        line_dirty[line_index(a)] = 1'b1;
        wait_response(cycles, traffic);
        cpu_w_req <= 1'b0;
        check_timing(mode, 1, cycles, traffic);
    endtask

    // refill beats wrap from the requested word and may stall
    always @(posedge clk) begin : refill_model
        logic [2:0]  wrd;
        logic [31:0] beat_a;
        if (rst) begin
            rd_active = 1'b0;
            mem_r_valid <= 1'b0;
        end else begin
            if (mem_r_valid && mem_r_ready) begin
                rd_beat = rd_beat + 1'b1;
            end
            if (!rd_active && mem_r_ready) begin
                rd_active = 1'b1;
                rd_beat   = '0;
                rd_base   = mem_r_addr;
                check_addr("mem_r_addr", {cpu_addr[31:3], 3'b000}, mem_r_addr);
            end
            if (rd_active && rd_beat == 4'd8) begin
                rd_active = 1'b0;
                mem_r_valid <= 1'b0;
            end else if (rd_active) begin
                wrd    = rd_base[5:3] + rd_beat[2:0];
                beat_a = {rd_base[31:6], wrd, 3'b000};
                mem_r_valid <= (rand_bits(2) != 0);
                mem_r_data  <= mem_model[mem_index(beat_a)];
            end
        end
    end

    // each write-back beat must match the image at its own address
    always @(posedge clk) begin : write_back_model
        logic [2:0]  wrd;
        logic [31:0] beat_a;
        if (rst) begin
            wb_beat = '0;
            mem_w_ready <= 1'b0;
        end else begin
            if (mem_w_valid && mem_w_ready) begin
                wrd    = mem_w_addr[5:3] + wb_beat;
                beat_a = {mem_w_addr[31:6], wrd, 3'b000};
                if (mem_w_addr[31:13] != '0 || mem_w_addr[9:8] != '0) begin
                    other_errs++;
                    $display("write-back at %0t to %h, a line no request touched",
                             $time, mem_w_addr);
                end else begin
                    if (wb_beat == 3'd0 && !line_dirty[line_index(mem_w_addr)]) begin
                        other_errs++;
                        $display("write-back at %0t of line %h, which had no write since",
                                 $time, {mem_w_addr[31:6], 6'd0});
                        $display("its last write-back or its fill from memory");
                    end
                    check_wb_beat({mem_w_addr[31:10], cpu_addr[9:3], 3'b000}, mem_w_addr,
                                  ref_word(beat_a), mem_w_data);
                    mem_model[mem_index(beat_a)] = mem_w_data;
                    if (wb_beat == 3'd7) begin
                        line_dirty[line_index(mem_w_addr)] = 1'b0;
                    end
                end
                if (wb_beat == 3'd7) begin
                    wb_bursts++;
                end
                wb_beat = wb_beat + 1'b1;
            end
            mem_w_ready <= (rand_bits(2) != 0);
        end
    end

    always @(posedge clk) begin : read_compare
        logic [cache_pkg::DATA_W-1:0] exp;
        if (!rst && cpu_r_valid) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("cpu_r_valid at %0t with no read pending", $time);
            end else begin
                exp = exp_q.pop_front();
                check_data("cpu_r_data", exp, cpu_r_data);
            end
        end
    end

    initial begin
        fill_memory();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_level("cpu_r_valid", 1'b0, cpu_r_valid);
        check_level("cpu_w_ready", 1'b0, cpu_w_ready);
        check_level("mem_w_valid", 1'b0, mem_w_valid);
        check_level("mem_r_ready", 1'b0, mem_r_ready);

        cpu_read(make_addr(3'd0, 2'd1, 3'd5), MISS);          // cold miss
        cpu_read(make_addr(3'd0, 2'd1, 3'd2), HIT);
        cpu_write(make_addr(3'd0, 2'd1, 3'd2), rand_word(), 8'(rand_bits(8)), HIT);
        cpu_read(make_addr(3'd0, 2'd1, 3'd2), HIT);

        cpu_write(make_addr(3'd1, 2'd3, 3'd6), rand_word(), 8'(rand_bits(8)), MISS);
        for (int w = 0; w < 8; w++) begin
            cpu_read(make_addr(3'd1, 2'd3, 3'(w)), HIT);
        end

        // eight tags into set 2 forces dirty evictions
        for (int p = 0; p < 3; p++) begin
            for (int t = 0; t < 8; t++) begin
                cpu_write(make_addr(3'(t), 2'd2, 3'(rand_bits(3))), rand_word(),
                          8'(rand_bits(8)), ANY);
            end
        end
        for (int i = 0; i < 48; i++) begin
            cpu_read(make_addr(3'(rand_bits(3)), 2'd2, 3'(rand_bits(3))), ANY);
        end

        wait_idle();
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("%0d reads never returned data", exp_q.size());
        end
        if (wb_bursts == 0) begin
            other_errs++;
            $display("no write-back burst was seen");
        end
        $display("errors: data=%0d addr=%0d ctrl=%0d other=%0d",
                 data_errs, addr_errs, ctrl_errs, other_errs);
        if (data_errs + addr_errs + ctrl_errs + other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* cache.f */
cache_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_ctrl.sv
cache_top.sv
tb_cache.sv

/* run.sh */
#!/bin/sh
# builds the cache testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f cache.f --top-module tb_cache -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cache > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi

exit 0
